// ==== include/synth_params.svh ====
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

`define SAMPLE_W           8       // One audio sample
`define I2S_WORD_W         16      // Two sample copies per word
`define UART_CLKS_PER_BIT  16      // Oversampling of the serial line
`define NOTE_PERIOD_W      16      // Holds the longest base period
`define LFSR_SEED          16'hACE1

// Base periods for octave 0, clk cycles per phase step
`define NOTE_PERIOD_0      16'd47878  // C
`define NOTE_PERIOD_1      16'd45090  // C sharp
`define NOTE_PERIOD_2      16'd42566  // D
`define NOTE_PERIOD_3      16'd40178  // D sharp
`define NOTE_PERIOD_4      16'd37878  // E
`define NOTE_PERIOD_5      16'd35793  // F
`define NOTE_PERIOD_6      16'd33783  // F sharp
`define NOTE_PERIOD_7      16'd31888  // G
`define NOTE_PERIOD_8      16'd30120  // G sharp
`define NOTE_PERIOD_9      16'd28409  // A
`define NOTE_PERIOD_10     16'd26881  // A sharp
`define NOTE_PERIOD_11     16'd25434  // B

`endif

// ==== logic/synth_pkg.sv ====
package synth_pkg;

    // Waveform shape picked by the letter commands
    typedef enum logic [1:0] {
        WAVE_TRI = 2'd0,
        WAVE_SAW = 2'd1,
        WAVE_SQR = 2'd2
    } wave_sel_e;

    // Note byte layout, bit 7 flags a note
    typedef struct packed {
        logic       is_note;
        logic [2:0] octave;    // Right shift of the base period
        logic [3:0] semitone;  // 0 is C, 11 is B
    } note_cmd_t;

    // One received byte, read as a letter or as a note
    typedef union packed {
        logic [7:0] ascii;
        note_cmd_t  note;
    } cmd_byte_u;

endpackage

// ==== logic/uart_cmd_rx.sv ====
`timescale 1ns/1ns
`include "synth_params.svh"

module uart_cmd_rx
    import synth_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rx,
    output note_cmd_t note,
    output wave_sel_e wave,
    output logic      noise_en
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_DATA = 2'd1,
        S_STOP = 2'd2
    } rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;   // Clocks within one bit
    logic [2:0]       bit_idx;   // Data bit being received
    cmd_byte_u        rx_byte;   // Shift register, LSB arrives first

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            note     <= '{is_note: 1'b1, octave: 3'd0, semitone: 4'd9};  // A
            wave     <= WAVE_TRI;
            noise_en <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rx) begin
                        bit_cnt <= '0;                    // Line idle or glitch
                    end else if (bit_cnt == CNT_MID) begin
                        bit_cnt <= '0;                    // Middle of start bit
                        bit_idx <= '0;
                        state   <= S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == CNT_LAST) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= S_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_cnt == CNT_LAST) begin
                        bit_cnt <= '0;
                        state   <= S_IDLE;
                        // Low stop bit means a broken frame, drop it
                        if (rx) begin
                            if (rx_byte.note.is_note) begin
                                if (rx_byte.note.semitone <= 4'd11)
                                    note <= rx_byte.note;
                            end else begin
                                case (rx_byte.ascii)
                                    8'h54:   wave     <= WAVE_TRI;  // 'T'
                                    8'h53:   wave     <= WAVE_SAW;  // 'S'
                                    8'h51:   wave     <= WAVE_SQR;  // 'Q'
                                    8'h4E:   noise_en <= 1'b1;      // 'N'
                                    8'h46:   noise_en <= 1'b0;      // 'F'
                                    default: ;
                                endcase
                            end
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data bits sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_cnt == CNT_LAST)
            rx_byte.ascii <= {rx, rx_byte.ascii[7:1]};
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {S_IDLE, S_DATA, S_STOP}
    );

endmodule

// ==== logic/note_timer.sv ====
`timescale 1ns/1ns
`include "synth_params.svh"

module note_timer
    import synth_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  note_cmd_t note,
    output logic      step
);

    logic [`NOTE_PERIOD_W-1:0] base_period;
    logic [`NOTE_PERIOD_W-1:0] period;
    logic [`NOTE_PERIOD_W-1:0] cnt;
    note_cmd_t                 note_q;     // Last note seen
    logic                      note_chg;

    // One octave of periods
    always_comb begin
        case (note.semitone)
            4'd0:    base_period = `NOTE_PERIOD_0;
            4'd1:    base_period = `NOTE_PERIOD_1;
            4'd2:    base_period = `NOTE_PERIOD_2;
            4'd3:    base_period = `NOTE_PERIOD_3;
            4'd4:    base_period = `NOTE_PERIOD_4;
            4'd5:    base_period = `NOTE_PERIOD_5;
            4'd6:    base_period = `NOTE_PERIOD_6;
            4'd7:    base_period = `NOTE_PERIOD_7;
            4'd8:    base_period = `NOTE_PERIOD_8;
            4'd9:    base_period = `NOTE_PERIOD_9;
            4'd10:   base_period = `NOTE_PERIOD_10;
            4'd11:   base_period = `NOTE_PERIOD_11;
            default: base_period = `NOTE_PERIOD_9;   // Receiver never passes these
        endcase
    end

    assign period   = base_period >> note.octave;  // Each octave halves it
    assign note_chg = (note != note_q);
    assign step     = (cnt == period - 1'b1) && !note_chg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt    <= '0;
            note_q <= '0;
        end else begin
            note_q <= note;
            if (note_chg || cnt == period - 1'b1)
                cnt <= '0;                 // Restart on wrap or new note
            else
                cnt <= cnt + 1'b1;
        end
    end

    a_step_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        step |=> !step
    );

endmodule

// ==== logic/wave_gen.sv ====
`timescale 1ns/1ns
`include "synth_params.svh"

module wave_gen
    import synth_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 step,
    input  wave_sel_e            wave,
    input  logic                 noise_en,
    output logic [`SAMPLE_W-1:0] sample
);

    logic [`SAMPLE_W-1:0] phase;
    logic [15:0]          lfsr;
    logic                 lfsr_fb;
    logic                 step_q;     // Sample loads a cycle after step
    logic [`SAMPLE_W-1:0] shaped;

    // Fibonacci taps 16, 14, 13, 11
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= '0;
            lfsr   <= `LFSR_SEED;
            step_q <= 1'b0;
        end else begin
            step_q <= step;
            if (step) begin
                phase <= phase + 1'b1;
                lfsr  <= {lfsr[14:0], lfsr_fb};
            end
        end
    end

    always_comb begin
        if (noise_en) begin
            shaped = lfsr[15 -: `SAMPLE_W];     // Noise wins over the shape
        end else begin
            case (wave)
                WAVE_SAW: shaped = phase;
                WAVE_SQR: shaped = {`SAMPLE_W{phase[`SAMPLE_W-1]}};
                default: begin
                    // Triangle, fold the second half down
                    if (phase[`SAMPLE_W-1])
                        shaped = {~phase[`SAMPLE_W-2:0], 1'b0};
                    else
                        shaped = {phase[`SAMPLE_W-2:0], 1'b0};
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            sample <= '0;
        else if (step_q)
            sample <= shaped;
    end

endmodule

// ==== logic/i2s_tx.sv ====
`timescale 1ns/1ns
`include "synth_params.svh"

module i2s_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`SAMPLE_W-1:0] sample,
    output logic                 sck,
    output logic                 ws,
    output logic                 sd
);

    localparam int BIT_W = $clog2(`I2S_WORD_W);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`I2S_WORD_W - 1);

    logic [BIT_W-1:0]       bit_cnt;    // Bit within the current word
    logic [`I2S_WORD_W-1:0] shift_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= BIT_LAST;            // First rise starts a word
        end else begin
            sck <= ~sck;
            if (!sck) begin
                // Rising sck
                if (bit_cnt == BIT_LAST) begin
                    bit_cnt <= '0;
                    ws      <= ~ws;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                sd <= shift_word[`I2S_WORD_W-1];  // Falling sck, MSB first
            end
        end
    end

    // Word latched at the start rise, shifted after each falling edge
    always_ff @(posedge clk) begin
        if (!sck && bit_cnt == BIT_LAST)
            shift_word <= {sample, sample};
        else if (sck)
            shift_word <= {shift_word[`I2S_WORD_W-2:0], 1'b0};
    end

    a_ws_at_word_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> ($rose(sck) && bit_cnt == '0)
    );

endmodule

// ==== logic/synth_top.sv ====
`timescale 1ns/1ns
`include "synth_params.svh"

module synth_top
    import synth_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic sck,
    output logic ws,
    output logic sd
);

    note_cmd_t            note;
    wave_sel_e            wave;
    logic                 noise_en;
    logic                 step;
    logic [`SAMPLE_W-1:0] sample;

    uart_cmd_rx u_cmd_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .note     (note),
        .wave     (wave),
        .noise_en (noise_en)
    );

    note_timer u_note_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .note  (note),
        .step  (step)
    );

    wave_gen u_wave_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (step),
        .wave     (wave),
        .noise_en (noise_en),
        .sample   (sample)
    );

    i2s_tx u_i2s_tx (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;  // 20 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is released on a falling edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== tb/tb_synth_top.sv ====
`timescale 1ns/1ns
`include "synth_params.svh"

module tb_synth_top;

    typedef enum {CHK_IDLE, CHK_SAW, CHK_SQR, CHK_TRI, CHK_NOISE} chk_mode_e;

    localparam int SETTLE_WORDS = 60;   // Longer than one step at octave 5

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        sck;
    logic        ws;
    logic        sd;

    chk_mode_e   mode       = CHK_IDLE;
    int          word_cnt   = 0;
    int          check_cnt  = 0;
    int          err_cnt    = 0;
    int          frame_errs = 0;
    int          test_errs;             // Error count when a test starts
    logic [7:0]  prev_s;
    bit          have_prev  = 1'b0;
    bit          seen [256];            // Sample values met since arming
    logic [7:0]  note_byte;
    logic [7:0]  saw_mark;              // Sawtooth sample when the bad note went out
    logic        sck_q      = 1'b0;
    logic        ws_q       = 1'b0;
    bit          started    = 1'b0;     // First word start seen
    logic [15:0] bits;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    synth_top u_synth_top (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    task automatic report_mismatch(string sig, int got, int expected);
        $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, expected);
        err_cnt++;
    endtask

    task automatic report_error(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic end_on_timeout(string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic finish_test(string name, int errs);
        if (errs == 0)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errs);
    endtask

    // Outputs low through reset and in the first cycle after it
    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |=> (!sck && !ws && !sd)
    ) else report_error("sck, ws or sd not low around reset");

    a_sd_on_fall: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(sd) |-> $fell(sck)
    ) else report_error("sd changed without a falling sck");

    task automatic check_word(logic [15:0] w);
        logic [7:0] s;
        logic [7:0] step_diff;
        int         d;
        s         = w[7:0];
        step_diff = s - prev_s;          // Modulo 256
        d         = int'(s) - int'(prev_s);
        check_cnt++;
        assert (w[15:8] == w[7:0]) else begin
            report_mismatch("sd word", w[15:8], w[7:0]);
            frame_errs++;
        end
        if (word_cnt == 0) begin
            check_cnt++;
            assert (w == 16'h0000) else report_mismatch("first sd word", w, 0);
        end
        case (mode)
            CHK_SAW: if (have_prev) begin
                check_cnt++;
                assert (step_diff <= 8'd1)
                    else report_mismatch("sawtooth sample", s, 8'(prev_s + 8'd1));
            end
            CHK_SQR: begin
                check_cnt++;
                assert (s == 8'h00 || s == 8'hFF)
                    else report_mismatch("square sample", s, {8{s[7]}});
            end
            CHK_TRI: if (have_prev) begin
                check_cnt++;
                assert (d >= -2 && d <= 2)
                    else report_mismatch("triangle sample", s, prev_s);
            end
            default: ;
        endcase
        seen[s]   = 1'b1;
        prev_s    = s;
        have_prev = 1'b1;
        word_cnt++;
    endtask

    // Rebuild each word from the bit clock with data valid at every sck rise
    always @(negedge clk) begin
        if (!rst_n) begin
            sck_q   = 1'b0;
            ws_q    = 1'b0;
            started = 1'b0;
        end else begin
            if (sck && !sck_q) begin
                bits = {bits[14:0], sd};
                if (ws != ws_q) begin
                    if (started)
                        check_word(bits);  // LSB of the last word came with ws
                    started = 1'b1;
                end
            end
            sck_q = sck;
            ws_q  = ws;
        end
    end

    task automatic arm(chk_mode_e m);
        have_prev = 1'b0;
        foreach (seen[i])
            seen[i] = 1'b0;
        mode = m;
    endtask

    task automatic send_frame(logic [7:0] b, logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, b, 1'b0};     // Start bit then data LSB first
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx = frame[i];
            repeat (`UART_CLKS_PER_BIT - 1) @(negedge clk);
        end
        @(negedge clk);
        rx = 1'b1;
        repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);  // Idle gap
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!rst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10)
                end_on_timeout("reset was never released");
        end
    endtask

    task automatic wait_words(int n);
        int target;
        int cycles;
        target = word_cnt + n;
        cycles = 0;
        while (word_cnt < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > n * 40 + 100)
                end_on_timeout($sformatf("%0d I2S words did not arrive", n));
        end
    endtask

    task automatic wait_square_extremes(int max_words);
        int start;
        int cycles;
        start  = word_cnt;
        cycles = 0;
        while (!(seen[0] && seen[255]) && word_cnt - start < max_words) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_words * 40)
                end_on_timeout("I2S words stopped during the square test");
        end
    endtask

    task automatic check_noise_spread();
        int distinct;
        distinct = 0;
        foreach (seen[i])
            if (seen[i])
                distinct++;
        check_cnt++;
        assert (distinct > 8)
            else report_error($sformatf("noise gave only %0d distinct samples", distinct));
    endtask

    initial begin
        rx = 1'b1;
        void'($urandom(46));

        test_errs = err_cnt;
        wait_reset_release();
        wait_words(1);
        finish_test("reset", err_cnt - test_errs);

        test_errs = err_cnt;
        note_byte = {1'b1, 3'(5 + $urandom % 3), 4'($urandom % 12)};
        send_frame("S", 1'b1);
        send_frame(note_byte, 1'b1);
        wait_words(SETTLE_WORDS);
        arm(CHK_SAW);
        wait_words(300);
        send_frame({1'b1, 3'd0, 4'd13}, 1'b1);  // Taken at octave 0 it would stall the ramp
        saw_mark = prev_s;
        wait_words(300);
        check_cnt++;
        assert (prev_s != saw_mark)
            else report_error("sawtooth stopped after a note byte with semitone 13");
        arm(CHK_IDLE);
        finish_test("sawtooth", err_cnt - test_errs);

        test_errs = err_cnt;
        note_byte = {1'b1, 3'd7, 4'($urandom % 12)};  // Half a cycle fits in 2000 words
        send_frame("Q", 1'b1);
        send_frame(note_byte, 1'b1);
        wait_words(SETTLE_WORDS);
        arm(CHK_SQR);
        wait_square_extremes(2000);
        check_cnt++;
        assert (seen[0] && seen[255])
            else report_error("square wave did not reach both 0 and 255 in 2000 words");
        arm(CHK_IDLE);
        finish_test("square", err_cnt - test_errs);

        test_errs = err_cnt;
        send_frame("T", 1'b1);
        wait_words(SETTLE_WORDS);
        arm(CHK_TRI);
        wait_words(300);
        arm(CHK_IDLE);
        send_frame("N", 1'b1);
        wait_words(SETTLE_WORDS);
        send_frame("F", 1'b1);
        wait_words(SETTLE_WORDS);
        arm(CHK_TRI);                    // Noise released again
        wait_words(300);
        arm(CHK_IDLE);
        finish_test("triangle", err_cnt - test_errs);

        test_errs = err_cnt;
        send_frame("Q", 1'b1);           // Square has only two values
        send_frame("N", 1'b1);
        wait_words(SETTLE_WORDS);
        arm(CHK_NOISE);
        wait_words(300);
        check_noise_spread();
        arm(CHK_IDLE);
        send_frame("F", 1'b0);           // Low stop bit
        wait_words(SETTLE_WORDS);
        arm(CHK_NOISE);
        wait_words(300);
        check_noise_spread();
        arm(CHK_IDLE);
        finish_test("noise", err_cnt - test_errs);

        finish_test("framing", frame_errs);
        $display("Checks: %0d, words: %0d, errors: %0d", check_cnt, word_cnt, err_cnt);
        if (err_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
logic/synth_pkg.sv
logic/uart_cmd_rx.sv
logic/note_timer.sv
logic/wave_gen.sv
logic/i2s_tx.sv
logic/synth_top.sv
tb/tb_clk_gen.sv
tb/tb_synth_top.sv

// ==== Bender.yml ====
package:
  name: tone_synth

export_include_dirs:
  - include

sources:
  - files:
      - logic/synth_pkg.sv
      - logic/uart_cmd_rx.sv
      - logic/note_timer.sv
      - logic/wave_gen.sv
      - logic/i2s_tx.sv
      - logic/synth_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_synth_top.sv
